/* common/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    localparam int WORD_WIDTH = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int REG_COUNT = 32;

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // First fetch address after reset
    localparam word_t RESET_VECTOR = 32'hbfc00000;
    localparam word_t WORD_BYTES = 32'd4;
    // Link skips the jump and its delay slot
    localparam word_t LINK_OFFSET = 32'd8;
    localparam reg_addr_t LINK_REG = 5'd31;
    localparam reg_addr_t V0_REG = 5'd2;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_t;

    // Function field of SPECIAL instructions
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_t;

    // J-type target is {rs, rt, imm} of the I view
    typedef union packed {
        struct packed {
            opcode_t   opcode;
            reg_addr_t rs;
            reg_addr_t rt;
            reg_addr_t rd;
            logic [4:0] shamt;
            funct_t    funct;
        } r_view;
        struct packed {
            opcode_t   opcode;
            reg_addr_t rs;
            reg_addr_t rt;
            logic [15:0] imm;
        } i_view;
    } instr_t;

endpackage

`default_nettype wire

/* hw/mips_cpu_harvard.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_harvard (
    input  logic            clk,
    input  logic            reset,
    input  logic            clk_enable,
    output logic            active,
    output mips_pkg::word_t register_v0,
    output mips_pkg::word_t instr_address,
    input  mips_pkg::word_t instr_readdata,
    output mips_pkg::word_t data_address,
    output logic            data_write,
    output logic            data_read,
    output mips_pkg::word_t data_writedata,
    input  mips_pkg::word_t data_readdata
);

    mips_pkg::instr_t    instr;
    mips_pkg::word_t     pc;
    mips_pkg::word_t     rs_data;
    mips_pkg::word_t     rt_data;
    mips_pkg::word_t     write_data;
    mips_pkg::reg_addr_t dest_reg;
    logic                reg_write;
    logic                commit;

    assign instr = mips_pkg::instr_t'(instr_readdata);
    assign instr_address = pc;

    mips_pc_unit u_pc_unit (
        .clk        (clk),
        .reset      (reset),
        .clk_enable (clk_enable),
        .instr      (instr),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .pc         (pc),
        .active     (active),
        .commit     (commit)
    );

    mips_regfile u_regfile (
        .clk         (clk),
        .reset       (reset),
        .commit      (commit),
        .reg_write   (reg_write),
        .dest_reg    (dest_reg),
        .write_data  (write_data),
        .rs_addr     (instr.r_view.rs),
        .rt_addr     (instr.r_view.rt),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .register_v0 (register_v0)
    );

    mips_execute u_execute (
        .instr          (instr),
        .pc             (pc),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .data_readdata  (data_readdata),
        .commit         (commit),
        .reg_write      (reg_write),
        .dest_reg       (dest_reg),
        .write_data     (write_data),
        .data_address   (data_address),
        .data_writedata (data_writedata),
        .data_write     (data_write),
        .data_read      (data_read)
    );

endmodule

`default_nettype wire

/* hw/mips_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_execute (
    input  mips_pkg::instr_t    instr,
    input  mips_pkg::word_t     pc,
    input  mips_pkg::word_t     rs_data,
    input  mips_pkg::word_t     rt_data,
    input  mips_pkg::word_t     data_readdata,
    input  logic                commit,
    output logic                reg_write,
    output mips_pkg::reg_addr_t dest_reg,
    output mips_pkg::word_t     write_data,
    output mips_pkg::word_t     data_address,
    output mips_pkg::word_t     data_writedata,
    output logic                data_write,
    output logic                data_read
);

    mips_pkg::opcode_t opcode;
    mips_pkg::funct_t  funct;
    logic [4:0]        shamt;
    logic [4:0]        shamt_var;
    mips_pkg::word_t   imm_sext;
    mips_pkg::word_t   imm_zext;
    mips_pkg::word_t   link_addr;
    logic              lt_signed;
    logic              lt_unsigned;
    logic              lt_imm_signed;
    logic              lt_imm_unsigned;

    assign opcode = instr.r_view.opcode;
    assign funct = instr.r_view.funct;
    assign shamt = instr.r_view.shamt;
    assign shamt_var = rs_data[4:0];

    assign imm_sext = {{16{instr.i_view.imm[15]}}, instr.i_view.imm};
    // Logical immediates
    assign imm_zext = {16'h0000, instr.i_view.imm};

    assign link_addr = pc + mips_pkg::LINK_OFFSET;

    assign lt_signed = $signed(rs_data) < $signed(rt_data);
    assign lt_unsigned = rs_data < rt_data;
    assign lt_imm_signed = $signed(rs_data) < $signed(imm_sext);
    // SLTIU still sign-extends, then compares unsigned
    assign lt_imm_unsigned = rs_data < imm_sext;

    always_comb begin
        reg_write = 1'b1;
        dest_reg = instr.i_view.rt;
        write_data = '0;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                dest_reg = instr.r_view.rd;
                case (funct)
                    mips_pkg::FN_SLL:  write_data = rt_data << shamt;
                    mips_pkg::FN_SRL:  write_data = rt_data >> shamt;
                    mips_pkg::FN_SRA:  write_data = $signed(rt_data) >>> shamt;
                    mips_pkg::FN_SLLV: write_data = rt_data << shamt_var;
                    mips_pkg::FN_SRLV: write_data = rt_data >> shamt_var;
                    mips_pkg::FN_SRAV: write_data = $signed(rt_data) >>> shamt_var;
                    mips_pkg::FN_JALR: write_data = link_addr;
                    mips_pkg::FN_ADDU: write_data = rs_data + rt_data;
                    mips_pkg::FN_SUBU: write_data = rs_data - rt_data;
                    mips_pkg::FN_AND:  write_data = rs_data & rt_data;
                    mips_pkg::FN_OR:   write_data = rs_data | rt_data;
                    mips_pkg::FN_XOR:  write_data = rs_data ^ rt_data;
                    mips_pkg::FN_SLT:  write_data = {31'd0, lt_signed};
                    mips_pkg::FN_SLTU: write_data = {31'd0, lt_unsigned};
                    // JR and unknown codes write nothing
                    default:           reg_write = 1'b0;
                endcase
            end
            mips_pkg::OP_JAL: begin
                dest_reg = mips_pkg::LINK_REG;
                write_data = link_addr;
            end
            mips_pkg::OP_ADDIU: write_data = rs_data + imm_sext;
            mips_pkg::OP_SLTI:  write_data = {31'd0, lt_imm_signed};
            mips_pkg::OP_SLTIU: write_data = {31'd0, lt_imm_unsigned};
            mips_pkg::OP_ANDI:  write_data = rs_data & imm_zext;
            mips_pkg::OP_ORI:   write_data = rs_data | imm_zext;
            mips_pkg::OP_XORI:  write_data = rs_data ^ imm_zext;
            mips_pkg::OP_LUI:   write_data = {instr.i_view.imm, 16'h0000};
            mips_pkg::OP_LW:    write_data = data_readdata;
            // Jumps, branches and stores
            default:            reg_write = 1'b0;
        endcase
    end

    assign data_address = rs_data + imm_sext;
    assign data_writedata = rt_data;
    assign data_read = (opcode == mips_pkg::OP_LW);
    assign data_write = commit && (opcode == mips_pkg::OP_SW);

endmodule

`default_nettype wire

/* hw/mips_pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_pc_unit (
    input  logic             clk,
    input  logic             reset,
    input  logic             clk_enable,
    input  mips_pkg::instr_t instr,
    input  mips_pkg::word_t  rs_data,
    input  mips_pkg::word_t  rt_data,
    output mips_pkg::word_t  pc,
    output logic             active,
    output logic             commit
);

    mips_pkg::opcode_t opcode;
    mips_pkg::funct_t  funct;
    mips_pkg::word_t   pc_plus4;
    mips_pkg::word_t   branch_target;
    mips_pkg::word_t   jump_target;
    mips_pkg::word_t   target;
    mips_pkg::word_t   slot_target;
    logic              taken;
    logic              pending;

    assign opcode = instr.i_view.opcode;
    assign funct = instr.r_view.funct;

    assign commit = active && clk_enable && (pc != '0);

    assign pc_plus4 = pc + mips_pkg::WORD_BYTES;
    assign branch_target = pc_plus4 + {{14{instr.i_view.imm[15]}}, instr.i_view.imm, 2'b00};
    assign jump_target = {pc[31:28], instr.i_view.rs, instr.i_view.rt, instr.i_view.imm, 2'b00};

    always_comb begin
        taken = 1'b0;
        target = branch_target;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                if (funct == mips_pkg::FN_JR || funct == mips_pkg::FN_JALR) begin
                    taken = 1'b1;
                    target = rs_data;
                end
            end
            mips_pkg::OP_J, mips_pkg::OP_JAL: begin
                taken = 1'b1;
                target = jump_target;
            end
            mips_pkg::OP_BEQ:  taken = (rs_data == rt_data);
            mips_pkg::OP_BNE:  taken = (rs_data != rt_data);
            mips_pkg::OP_BGTZ: taken = ($signed(rs_data) > 0);
            mips_pkg::OP_BLEZ: taken = ($signed(rs_data) <= 0);
            default:           taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= mips_pkg::RESET_VECTOR;
            active <= 1'b1;
            pending <= 1'b0;
        end else if (commit) begin
            // Delay slot retires, then the stored target takes over
            pc <= pending ? slot_target : pc_plus4;
            pending <= taken;
        end else if (active && clk_enable) begin
            // Only reached with pc at zero
            active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (commit && taken) begin
            slot_target <= target;
        end
    end

endmodule

`default_nettype wire

/* hw/mips_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
    input  logic               clk,
    input  logic               reset,
    input  logic               commit,
    input  logic               reg_write,
    input  mips_pkg::reg_addr_t dest_reg,
    input  mips_pkg::word_t     write_data,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    output mips_pkg::word_t     register_v0
);

    mips_pkg::word_t regs [mips_pkg::REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mips_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (commit && reg_write && (dest_reg != '0)) begin
            // $zero is never written, so it reads back as 0
            regs[dest_reg] <= write_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    assign register_v0 = regs[mips_pkg::V0_REG];

endmodule

`default_nettype wire

/* mips_cpu.f */
common/mips_pkg.sv
hw/mips_regfile.sv
hw/mips_execute.sv
hw/mips_pc_unit.sv
hw/mips_cpu_harvard.sv
verification/mips_cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module mips_cpu_tb -f mips_cpu.f -o mips_cpu_sim

./obj_dir/mips_cpu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log || ! grep -q "TEST RESULT: PASS" sim.log; then
    exit 1
fi

/* verification/mips_cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_tb;

    localparam int TEST_COUNT = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int CLK_PERIOD_NS = 10;

    logic            clk = 1'b0;
    logic            reset;
    logic            clk_enable;
    logic            active;
    logic            data_write;
    logic            data_read;
    mips_pkg::word_t register_v0;
    mips_pkg::word_t instr_address;
    mips_pkg::word_t instr_readdata;
    mips_pkg::word_t instr_offset;
    mips_pkg::word_t data_address;
    mips_pkg::word_t data_writedata;
    mips_pkg::word_t data_readdata;
    mips_pkg::word_t imem [256];
    mips_pkg::word_t dmem [256];
    mips_pkg::word_t alu_expected [$];
    mips_pkg::word_t path_expected;
    mips_pkg::word_t op_a;
    mips_pkg::word_t op_b;
    logic [15:0]     op_imm;
    int              path_bit;
    int              prog_len;

    mips_cpu_harvard dut (.*);

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    // Word index from the boot address, address zero reads as a no-op
    assign instr_offset = instr_address - mips_pkg::RESET_VECTOR;
    assign instr_readdata = (instr_address == '0) ? '0 : imem[instr_offset[9:2]];
    assign data_readdata = dmem[data_address[9:2]];

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i[7:0]] <= 32'hd0000000 | (i * 4);
            end
        end else if (data_write) begin
            dmem[data_address[9:2]] <= data_writedata;
        end
    end

    initial begin
        #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD_NS);
        $display("watchdog expired before all tests finished");
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    task automatic check_word(input string test, input mips_pkg::word_t expected,
                              input mips_pkg::word_t actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", test, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string test, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s: expected %b, actual %b", test, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // Memory strobes, sampled mid-cycle
    always @(negedge clk) begin
        if (reset === 1'b0) begin
            check_bit("data_read", instr_readdata[31:26] == mips_pkg::OP_LW, data_read);
            if (!(active && clk_enable)) begin
                check_bit("data_write", 1'b0, data_write);
            end
        end
    end

    function automatic mips_pkg::word_t r_type(input mips_pkg::reg_addr_t rs, rt, rd,
                                               input logic [4:0] shamt,
                                               input mips_pkg::funct_t funct);
        return {mips_pkg::OP_SPECIAL, rs, rt, rd, shamt, funct};
    endfunction

    function automatic mips_pkg::word_t i_type(input mips_pkg::opcode_t op,
                                               input mips_pkg::reg_addr_t rs, rt,
                                               input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mips_pkg::word_t j_type(input mips_pkg::opcode_t op,
                                               input mips_pkg::word_t target);
        return {op, target[27:2]};
    endfunction

    function automatic mips_pkg::word_t addr_of(input int index);
        return mips_pkg::RESET_VECTOR + mips_pkg::word_t'(index * 4);
    endfunction

    task automatic emit(input mips_pkg::word_t word);
        imem[prog_len[7:0]] = word;
        prog_len++;
    endtask

    task automatic clear_program();
        for (int i = 0; i < 256; i++) begin
            imem[i[7:0]] = i_type(mips_pkg::OP_ADDIU, 0, 0, i[15:0]);
        end
        prog_len = 0;
    endtask

    task automatic load_const(input mips_pkg::reg_addr_t rt, input mips_pkg::word_t value);
        emit(i_type(mips_pkg::OP_LUI, 0, rt, value[31:16]));
        emit(i_type(mips_pkg::OP_ORI, rt, rt, value[15:0]));
    endtask

    // JR $0 and its delay slot
    task automatic end_program();
        emit(r_type(0, 0, 0, 0, mips_pkg::FN_JR));
        emit('0);
    endtask

    // Jump, its delay slot, then one instruction skipped when taken
    task automatic emit_branch(input mips_pkg::word_t branch, input bit taken);
        emit(branch);
        emit(i_type(mips_pkg::OP_ORI, 2, 2, 16'(1 << path_bit)));
        emit(i_type(mips_pkg::OP_ORI, 2, 2, 16'(2 << path_bit)));
        path_expected |= 32'(1 << path_bit);
        if (!taken) begin
            path_expected |= 32'(2 << path_bit);
        end
        path_bit += 2;
    endtask

    task automatic add_alu(input mips_pkg::word_t instr, input mips_pkg::word_t expected);
        emit(instr);
        emit(i_type(mips_pkg::OP_SW, 0, 2, 16'(alu_expected.size() * 4)));
        alu_expected.push_back(expected);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        clk_enable <= 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        clk_enable <= 1'b1;
        @(negedge clk);
    endtask

    task automatic run_until_halt(input bit stalls);
        int hold;
        hold = 0;
        while (active) begin
            @(posedge clk);
            if (stalls && hold == 0 && $urandom_range(3, 0) == 0) begin
                hold = $urandom_range(3, 1);
            end
            if (hold > 0) begin
                clk_enable <= 1'b0;
                hold--;
            end else begin
                clk_enable <= 1'b1;
            end
            @(negedge clk);
        end
    endtask

    task automatic test_halt();
        clear_program();
        end_program();
        apply_reset();
        check_bit("halt", 1'b1, active);
        check_word("halt", mips_pkg::RESET_VECTOR, instr_address);
        run_until_halt(1'b0);
        check_bit("halt", 1'b0, active);
        check_word("halt", '0, register_v0);
        repeat (5) begin
            @(posedge clk);
            clk_enable <= 1'b1;
            @(negedge clk);
            check_word("halt", '0, register_v0);
            check_word("halt", '0, instr_address);
            check_bit("halt", 1'b0, data_write);
            check_bit("halt", 1'b0, active);
        end
    endtask

    task automatic test_alu(input string test, input bit stalls);
        mips_pkg::word_t imm_sext;
        mips_pkg::word_t imm_zext;
        logic [4:0]      sh;
        imm_sext = {{16{op_imm[15]}}, op_imm};
        imm_zext = {16'h0000, op_imm};
        sh = op_b[4:0];
        clear_program();
        alu_expected.delete();
        load_const(8, op_a);
        load_const(9, op_b);
        add_alu(r_type(8, 9, 2, 0, mips_pkg::FN_ADDU), op_a + op_b);
        add_alu(r_type(8, 9, 2, 0, mips_pkg::FN_SUBU), op_a - op_b);
        add_alu(r_type(8, 9, 2, 0, mips_pkg::FN_AND), op_a & op_b);
        add_alu(r_type(8, 9, 2, 0, mips_pkg::FN_OR), op_a | op_b);
        add_alu(r_type(8, 9, 2, 0, mips_pkg::FN_XOR), op_a ^ op_b);
        // a negative, b positive
        add_alu(r_type(8, 9, 2, 0, mips_pkg::FN_SLT), 32'd1);
        add_alu(r_type(8, 9, 2, 0, mips_pkg::FN_SLTU), 32'd0);
        add_alu(r_type(0, 8, 2, sh, mips_pkg::FN_SLL), op_a << sh);
        add_alu(r_type(0, 8, 2, sh, mips_pkg::FN_SRL), op_a >> sh);
        add_alu(r_type(0, 8, 2, sh, mips_pkg::FN_SRA), (op_a >> sh) | ~(32'hffffffff >> sh));
        add_alu(r_type(9, 8, 2, 0, mips_pkg::FN_SLLV), op_a << sh);
        add_alu(r_type(9, 8, 2, 0, mips_pkg::FN_SRLV), op_a >> sh);
        add_alu(r_type(9, 8, 2, 0, mips_pkg::FN_SRAV), (op_a >> sh) | ~(32'hffffffff >> sh));
        add_alu(i_type(mips_pkg::OP_ADDIU, 8, 2, op_imm), op_a + imm_sext);
        // Immediate is negative after sign extension
        add_alu(i_type(mips_pkg::OP_SLTI, 9, 2, op_imm), 32'd0);
        add_alu(i_type(mips_pkg::OP_SLTIU, 9, 2, op_imm), 32'd1);
        add_alu(i_type(mips_pkg::OP_ANDI, 8, 2, op_imm), op_a & imm_zext);
        add_alu(i_type(mips_pkg::OP_ORI, 8, 2, op_imm), op_a | imm_zext);
        add_alu(i_type(mips_pkg::OP_XORI, 8, 2, op_imm), op_a ^ imm_zext);
        add_alu(i_type(mips_pkg::OP_LUI, 0, 2, op_imm), {op_imm, 16'h0000});
        end_program();
        apply_reset();
        run_until_halt(stalls);
        foreach (alu_expected[k]) begin
            check_word(test, alu_expected[k], dmem[k[7:0]]);
        end
        check_word(test, alu_expected[alu_expected.size() - 1], register_v0);
        check_bit(test, 1'b0, active);
    endtask

    task automatic test_memory();
        mips_pkg::word_t value;
        mips_pkg::word_t address;
        logic [15:0]     offset;
        value = $urandom;
        offset = 16'hfff8;
        address = 32'h00000200 + {{16{offset[15]}}, offset};
        clear_program();
        load_const(10, 32'h00000200);
        load_const(11, value);
        emit(i_type(mips_pkg::OP_SW, 10, 11, offset));
        emit(i_type(mips_pkg::OP_LW, 10, 2, offset));
        end_program();
        apply_reset();
        run_until_halt(1'b0);
        check_word("memory", value, register_v0);
        check_word("memory", value, dmem[address[9:2]]);
        check_word("memory", 32'hd0000000 | (address + 4), dmem[address[9:2] + 8'd1]);
    endtask

    task automatic test_branches();
        clear_program();
        path_bit = 0;
        path_expected = '0;
        emit(i_type(mips_pkg::OP_ORI, 0, 8, 16'd5));
        emit(i_type(mips_pkg::OP_ORI, 0, 9, 16'd5));
        emit(i_type(mips_pkg::OP_LUI, 0, 10, 16'h8000));
        emit_branch(i_type(mips_pkg::OP_BEQ, 8, 9, 16'd2), 1'b1);
        emit_branch(i_type(mips_pkg::OP_BNE, 8, 0, 16'd2), 1'b1);
        emit_branch(i_type(mips_pkg::OP_BGTZ, 8, 0, 16'd2), 1'b1);
        emit_branch(i_type(mips_pkg::OP_BLEZ, 10, 0, 16'd2), 1'b1);
        emit_branch(i_type(mips_pkg::OP_BEQ, 8, 0, 16'd2), 1'b0);
        emit_branch(i_type(mips_pkg::OP_BNE, 8, 9, 16'd2), 1'b0);
        emit_branch(i_type(mips_pkg::OP_BGTZ, 10, 0, 16'd2), 1'b0);
        emit_branch(i_type(mips_pkg::OP_BLEZ, 8, 0, 16'd2), 1'b0);
        end_program();
        apply_reset();
        run_until_halt(1'b0);
        check_word("branches", path_expected, register_v0);
    endtask

    // JAL sits at word 3 and JALR at word 13
    task automatic test_jumps();
        clear_program();
        path_bit = 0;
        path_expected = '0;
        emit_branch(j_type(mips_pkg::OP_J, addr_of(3)), 1'b1);
        emit_branch(j_type(mips_pkg::OP_JAL, addr_of(6)), 1'b1);
        load_const(8, addr_of(11));
        emit_branch(r_type(8, 0, 0, 0, mips_pkg::FN_JR), 1'b1);
        load_const(9, addr_of(16));
        emit_branch(r_type(9, 0, 3, 0, mips_pkg::FN_JALR), 1'b1);
        emit(i_type(mips_pkg::OP_SW, 0, 2, 16'd8));
        emit(r_type(31, 0, 2, 0, mips_pkg::FN_ADDU));
        emit(i_type(mips_pkg::OP_SW, 0, 2, 16'd0));
        emit(r_type(3, 0, 2, 0, mips_pkg::FN_ADDU));
        end_program();
        apply_reset();
        run_until_halt(1'b0);
        check_word("jumps", path_expected, dmem[2]);
        check_word("jumps", addr_of(3) + 32'd8, dmem[0]);
        check_word("jumps", addr_of(13) + 32'd8, register_v0);
    endtask

    initial begin
        void'($urandom(32'hd4a1));
        reset <= 1'b1;
        clk_enable <= 1'b0;
        clear_program();
        // Negative a and positive b split the signed and unsigned compares
        op_a = $urandom | 32'h80000000;
        op_b = $urandom & 32'h7fffffff;
        op_imm = 16'($urandom) | 16'h8000;
        test_halt();
        test_alu("alu", 1'b0);
        test_memory();
        test_branches();
        test_jumps();
        test_alu("stall", 1'b1);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
